// File: Bender.yml
package:
  name: axi_rd_xbar_2x2

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_rd_pkg.sv
      - rtl/xbar_map_pkg.sv
      - rtl/ar_req_fsm.sv
      - rtl/rr_arbiter.sv
      - rtl/ar_target_port.sv
      - rtl/r_resp_router.sv
      - rtl/r_master_port.sv
      - rtl/decerr_read_target.sv
      - rtl/axi_rd_xbar_2x2.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/tb_axi_rd_xbar.sv

// File: axi_rd_xbar_2x2.f
+incdir+rtl
rtl/axi_rd_pkg.sv
rtl/xbar_map_pkg.sv
rtl/ar_req_fsm.sv
rtl/rr_arbiter.sv
rtl/ar_target_port.sv
rtl/r_resp_router.sv
rtl/r_master_port.sv
rtl/decerr_read_target.sv
rtl/axi_rd_xbar_2x2.sv
bench/tb_axi_rd_xbar.sv

// File: bench/rd_xbar_trace.txt
# Columns in hex: group master id address len expected_target expected_resp
# Same group issues in the same cycle; target 2 is the error target, resp 3 is DECERR
00 0 3 00000100 03 0 0
01 1 5 00010040 00 1 0
02 0 a 00020000 02 2 3
03 1 f 80000000 00 2 3
04 0 1 00001000 07 0 0
04 1 2 00002000 07 0 0
05 0 4 00010200 03 1 0
05 1 6 00000300 05 0 0
06 0 7 0000fffc 00 0 0
06 1 8 00010000 01 1 0
07 0 9 0001fffc 00 1 0
07 1 0 00030000 03 2 3
08 0 c 00000010 0f 0 0
08 1 d 00000020 0f 0 0
09 0 e 00011000 02 1 0
09 1 e 00011100 02 1 0
0a 0 2 ffff0000 01 2 3
0a 1 3 00020004 02 2 3
0b 0 5 00004000 04 0 0
0b 1 9 00014000 06 1 0
0c 0 0 00008888 01 0 0
0c 1 1 00018888 01 1 0
0d 0 b 00000040 1f 0 0
0d 1 c 00010080 1f 1 0
0e 1 4 0000c000 00 0 0
0e 0 6 00050000 00 2 3

// File: bench/tb_axi_rd_xbar.sv
/*
 * Self-checking testbench for the 2x2 AXI4 read crossbar. Reads transactions
 * from the trace file, models both slaves and checks every AR and R beat.
 */
`include "axi_rd_xbar_settings.svh"

module tb_axi_rd_xbar;
	import axi_rd_pkg::*;

	localparam int N_M = `XBAR_N_MST;
	localparam int N_S = `XBAR_N_SLV;
	localparam int TGT_ERR = `XBAR_N_SLV;
	localparam int MAX_TR = 64;
	localparam int PEND = 8;

	logic clk;
	logic rstn;
	mst_ar_t m_ar [N_M];
	logic m_arvalid [N_M] = '{default: 1'b0};
	logic m_arready [N_M];
	mst_r_t m_r [N_M];
	logic m_rvalid [N_M];
	logic m_rready [N_M] = '{default: 1'b0};
	slv_ar_t s_ar [N_S];
	logic s_arvalid [N_S];
	logic s_arready [N_S] = '{default: 1'b0};
	slv_r_t s_r [N_S] = '{default: '0};
	logic s_rvalid [N_S] = '{default: 1'b0};
	logic s_rready [N_S];

	// Trace columns
	int n_tr;
	int tr_grp [MAX_TR];
	int tr_mst [MAX_TR];
	int tr_id [MAX_TR];
	logic [31:0] tr_addr [MAX_TR];
	int tr_len [MAX_TR];
	int tr_tgt [MAX_TR];
	int tr_resp [MAX_TR];

	// Per master counts of issued, accepted and finished reads
	int cur [N_M] = '{default: 0};
	int issued [N_M] = '{default: 0};
	int acked [N_M] = '{default: 0};
	int done [N_M] = '{default: 0};
	int beat [N_M] = '{default: 0};

	// Slave models keep accepted requests in a small ring
	slv_ar_t pend [N_S][PEND];
	int wr_ptr [N_S] = '{default: 0};
	int rd_ptr [N_S] = '{default: 0};
	int sbeat [N_S] = '{default: 0};

	int cycles = 0;
	int limit = 200;

	axi_rd_xbar_2x2 UUT (
		.clk(clk),
		.rstn(rstn),
		.m0_ar_i(m_ar[0]),
		.m0_arvalid_i(m_arvalid[0]),
		.m0_arready_o(m_arready[0]),
		.m0_r_o(m_r[0]),
		.m0_rvalid_o(m_rvalid[0]),
		.m0_rready_i(m_rready[0]),
		.m1_ar_i(m_ar[1]),
		.m1_arvalid_i(m_arvalid[1]),
		.m1_arready_o(m_arready[1]),
		.m1_r_o(m_r[1]),
		.m1_rvalid_o(m_rvalid[1]),
		.m1_rready_i(m_rready[1]),
		.s0_ar_o(s_ar[0]),
		.s0_arvalid_o(s_arvalid[0]),
		.s0_arready_i(s_arready[0]),
		.s0_r_i(s_r[0]),
		.s0_rvalid_i(s_rvalid[0]),
		.s0_rready_o(s_rready[0]),
		.s1_ar_o(s_ar[1]),
		.s1_arvalid_o(s_arvalid[1]),
		.s1_arready_i(s_arready[1]),
		.s1_r_i(s_r[1]),
		.s1_rvalid_i(s_rvalid[1]),
		.s1_rready_o(s_rready[1])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int g;
		int m;
		int id;
		int len;
		int tgt;
		int resp;
		logic [31:0] addr;
		string line;
		fd = $fopen("bench/rd_xbar_trace.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Could not open the trace file bench/rd_xbar_trace.txt");
		end else begin
			n_tr = 0;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h", g, m, id, addr, len, tgt, resp);
					if (n == 7 && n_tr < MAX_TR) begin
						tr_grp[n_tr] = g;
						tr_mst[n_tr] = m;
						tr_id[n_tr] = id;
						tr_addr[n_tr] = addr;
						tr_len[n_tr] = len;
						tr_tgt[n_tr] = tgt;
						tr_resp[n_tr] = resp;
						limit = limit + 50 * (len + 1);
						n_tr++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task issue(input int e);
		int m;
		m = tr_mst[e];
		m_ar[m].addr <= tr_addr[e];
		m_ar[m].id <= mid_t'(tr_id[e]);
		m_ar[m].len <= len_t'(tr_len[e]);
		m_ar[m].size <= 3'd2;
		m_ar[m].burst <= 2'b01;
		m_ar[m].prot <= 3'(e);
		cur[m] <= e;
		issued[m] <= issued[m] + 1;
	endtask

	task automatic check_reset_state();
		for (int m = 0; m < N_M; m++) begin
			check($sformatf("m%0d_arready", m), m_arready[m], 1);
			check($sformatf("m%0d_rvalid", m), m_rvalid[m], 0);
		end
		for (int j = 0; j < N_S; j++) begin
			check($sformatf("s%0d_arvalid", j), s_arvalid[j], 0);
			check($sformatf("s%0d_rready", j), s_rready[j], 0);
		end
	endtask

	task automatic check_slave_ar(input int j);
		int m;
		int e;
		m = int'(s_ar[j].id >> `XBAR_ID_W);
		e = cur[m];
		if (issued[m] == done[m]) begin
			stop_with_failure($sformatf("Slave %0d got a request from idle master %0d", j, m));
		end else begin
			check($sformatf("s%0d target of entry %0d", j, e), j, tr_tgt[e]);
			check($sformatf("s%0d_ar.addr", j), s_ar[j].addr, tr_addr[e]);
			check($sformatf("s%0d_ar.id", j), mid_t'(s_ar[j].id), tr_id[e]);
			check($sformatf("s%0d_ar.len", j), s_ar[j].len, tr_len[e]);
			check($sformatf("s%0d_ar.size", j), s_ar[j].size, 2);
			check($sformatf("s%0d_ar.burst", j), s_ar[j].burst, 1);
			check($sformatf("s%0d_ar.prot", j), s_ar[j].prot, e % 8);
		end
	endtask

	task automatic check_beat(input int m);
		int e;
		logic [31:0] exp_data;
		e = cur[m];
		if (issued[m] == done[m]) begin
			stop_with_failure($sformatf("Master %0d got a read beat with no read pending", m));
		end else begin
			// Slave models return address plus 4 per beat and the error target zeros
			exp_data = (tr_tgt[e] == TGT_ERR) ? 32'h0 : tr_addr[e] + 32'(4 * beat[m]);
			check($sformatf("m%0d_r.id", m), m_r[m].id, tr_id[e]);
			check($sformatf("m%0d_r.data", m), m_r[m].data, exp_data);
			check($sformatf("m%0d_r.resp", m), m_r[m].resp, tr_resp[e]);
			check($sformatf("m%0d_r.last", m), m_r[m].last, beat[m] == tr_len[e]);
			if (m_r[m].last) begin
				beat[m] = 0;
				done[m] = done[m] + 1;
			end else begin
				beat[m] = beat[m] + 1;
			end
		end
	endtask

	always @(posedge clk) begin : models
		slv_ar_t a;
		if (cycles == 0) begin
			void'($urandom(74));
		end
		cycles = cycles + 1;
		if (cycles > limit) begin
			stop_with_failure($sformatf("Timeout: reads still pending after %0d cycles", limit));
		end else begin
			for (int m = 0; m < N_M; m++) begin
				if (m_arvalid[m] && m_arready[m]) begin
					acked[m] = acked[m] + 1;
				end
				m_arvalid[m] <= (issued[m] != acked[m]);
				if (m_rvalid[m] && m_rready[m]) begin
					check_beat(m);
				end
				m_rready[m] <= ($urandom % 4) != 0;
			end
			for (int j = 0; j < N_S; j++) begin
				if (s_arvalid[j] && s_arready[j]) begin
					check_slave_ar(j);
					pend[j][wr_ptr[j] % PEND] = s_ar[j];
					wr_ptr[j] = wr_ptr[j] + 1;
				end
				if (s_rvalid[j] && s_rready[j]) begin
					if (s_r[j].last) begin
						rd_ptr[j] = rd_ptr[j] + 1;
						sbeat[j] = 0;
					end else begin
						sbeat[j] = sbeat[j] + 1;
					end
				end
				if (wr_ptr[j] != rd_ptr[j]) begin
					a = pend[j][rd_ptr[j] % PEND];
					s_r[j].id <= a.id;
					s_r[j].data <= a.addr + 32'(4 * sbeat[j]);
					s_r[j].resp <= RESP_OKAY;
					s_r[j].last <= (sbeat[j] == int'(a.len));
					s_rvalid[j] <= 1'b1;
				end else begin
					s_rvalid[j] <= 1'b0;
				end
				s_arready[j] <= ($urandom % 3) != 0;
			end
		end
	end

	initial begin : stimulus
		int i;
		int g;
		bit waiting;
		for (int m = 0; m < N_M; m++) begin
			m_ar[m] <= '0;
		end
		rstn <= 1'b0;
		load_trace();
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		check_reset_state();
		i = 0;
		while (i < n_tr) begin
			g = tr_grp[i];
			// One group goes out in the same cycle
			while (i < n_tr && tr_grp[i] == g) begin
				issue(i);
				i++;
			end
			do begin
				@(negedge clk);
				waiting = 1'b0;
				for (int m = 0; m < N_M; m++) begin
					if (acked[m] != issued[m] || done[m] != issued[m]) begin
						waiting = 1'b1;
					end
				end
			end while (waiting);
			@(posedge clk);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: rtl/ar_req_fsm.sv
/*
 * Per-master read request stage. Captures one AR, tags its ID with the master
 * index, decodes the target and holds the request until that target takes it.
 */
`include "axi_rd_xbar_settings.svh"

module ar_req_fsm (
	input  logic clk,
	input  logic rstn,
	input  xbar_map_pkg::mst_idx_t mst_idx_i,
	input  axi_rd_pkg::mst_ar_t ar_i,
	input  logic arvalid_i,
	input  logic [xbar_map_pkg::N_TGT-1:0] gnt_i,
	input  logic [xbar_map_pkg::N_TGT-1:0] tgt_arready_i,
	output logic arready_o,
	output axi_rd_pkg::slv_ar_t req_o,
	output xbar_map_pkg::tgt_idx_t tgt_o,
	output logic req_valid_o
);
	import axi_rd_pkg::*;
	import xbar_map_pkg::*;

	ar_state_e state;
	slv_ar_t req_q;
	tgt_idx_t tgt_q;

	function automatic tgt_idx_t decode(addr_t addr);
		if (addr >= `XBAR_SLV0_BASE && addr <= `XBAR_SLV0_LIMIT) begin
			return tgt_idx_t'(0);
		end
		if (addr >= `XBAR_SLV1_BASE && addr <= `XBAR_SLV1_LIMIT) begin
			return tgt_idx_t'(1);
		end
		return TGT_DECERR;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= AR_IDLE;
			tgt_q <= TGT_DECERR;
		end else begin
			case (state)
				AR_IDLE: begin
					if (arvalid_i) begin
						state <= AR_DECODE;
					end
				end
				AR_DECODE: begin
					tgt_q <= decode(req_q.addr);
					state <= AR_REQUEST;
				end
				AR_REQUEST: begin
					// Done once our target has granted us and accepts
					if (gnt_i[tgt_q] && tgt_arready_i[tgt_q]) begin
						state <= AR_IDLE;
					end
				end
				default: state <= AR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == AR_IDLE && arvalid_i) begin
			req_q.addr <= ar_i.addr;
			req_q.id <= {mst_idx_i, ar_i.id};
			req_q.len <= ar_i.len;
			req_q.size <= ar_i.size;
			req_q.burst <= ar_i.burst;
			req_q.prot <= ar_i.prot;
		end
	end

	assign arready_o = (state == AR_IDLE);
	assign req_valid_o = (state == AR_REQUEST);
	assign req_o = req_q;
	assign tgt_o = tgt_q;

	// A pending request sees no grant left over from another target
	assert property (@(posedge clk) disable iff (!rstn)
		req_valid_o |-> (gnt_i & ~(N_TGT'(1) << tgt_o)) == '0);

endmodule

// File: rtl/ar_target_port.sv
/*
 * AR side of one target. Collects the masters whose decoded request names this
 * target, arbitrates between them and drives the winner's request out.
 */
module ar_target_port (
	input  logic clk,
	input  logic rstn,
	input  xbar_map_pkg::tgt_idx_t tgt_idx_i,
	input  axi_rd_pkg::slv_ar_t [xbar_map_pkg::N_MST-1:0] mst_req_i,
	input  xbar_map_pkg::tgt_idx_t [xbar_map_pkg::N_MST-1:0] mst_tgt_i,
	input  logic [xbar_map_pkg::N_MST-1:0] mst_valid_i,
	input  logic arready_i,
	output logic [xbar_map_pkg::N_MST-1:0] gnt_o,
	output axi_rd_pkg::slv_ar_t ar_o,
	output logic arvalid_o
);
	import xbar_map_pkg::*;

	logic [N_MST-1:0] req;
	mst_idx_t gnt_id;

	always_comb begin
		for (int m = 0; m < N_MST; m++) begin
			req[m] = mst_valid_i[m] && (mst_tgt_i[m] == tgt_idx_i);
		end
	end

	rr_arbiter #(
		.N_REQ(N_MST)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req),
		.gnt_o(gnt_o),
		.gnt_id_o(gnt_id)
	);

	assign ar_o = (gnt_o != '0) ? mst_req_i[gnt_id] : '0;
	assign arvalid_o = (gnt_o != '0) && req[gnt_id];

	// Payload holds under back-pressure through the request FSM and the held grant
	assert property (@(posedge clk) disable iff (!rstn)
		arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

endmodule

// File: rtl/axi_rd_pkg.sv
/*
 * AXI4 read channel types as seen on the master and slave sides of the crossbar.
 * Slave-side IDs carry the issuing master index above the master ID.
 */
`include "axi_rd_xbar_settings.svh"

package axi_rd_pkg;

	typedef logic [`XBAR_ADDR_W-1:0] addr_t;
	typedef logic [`XBAR_DATA_W-1:0] data_t;
	typedef logic [`XBAR_ID_W-1:0] mid_t;
	typedef logic [`XBAR_ID_W+$clog2(`XBAR_N_MST)-1:0] sid_t;
	typedef logic [7:0] len_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	typedef struct packed {
		addr_t addr;
		mid_t id;
		len_t len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [2:0] prot;
	} mst_ar_t;

	typedef struct packed {
		addr_t addr;
		sid_t id;
		len_t len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [2:0] prot;
	} slv_ar_t;

	typedef struct packed {
		sid_t id;
		data_t data;
		resp_t resp;
		logic last;
	} slv_r_t;

	typedef struct packed {
		mid_t id;
		data_t data;
		resp_t resp;
		logic last;
	} mst_r_t;

endpackage

// File: rtl/axi_rd_xbar_2x2.sv
/*
 * Read half of a 2x2 AXI4 crossbar. Per-master request FSMs feed per-target
 * arbiters, and R bursts return through per-master arbiters.
 */
module axi_rd_xbar_2x2 (
	input  logic clk,
	input  logic rstn,
	input  axi_rd_pkg::mst_ar_t m0_ar_i,
	input  logic m0_arvalid_i,
	output logic m0_arready_o,
	output axi_rd_pkg::mst_r_t m0_r_o,
	output logic m0_rvalid_o,
	input  logic m0_rready_i,
	input  axi_rd_pkg::mst_ar_t m1_ar_i,
	input  logic m1_arvalid_i,
	output logic m1_arready_o,
	output axi_rd_pkg::mst_r_t m1_r_o,
	output logic m1_rvalid_o,
	input  logic m1_rready_i,
	output axi_rd_pkg::slv_ar_t s0_ar_o,
	output logic s0_arvalid_o,
	input  logic s0_arready_i,
	input  axi_rd_pkg::slv_r_t s0_r_i,
	input  logic s0_rvalid_i,
	output logic s0_rready_o,
	output axi_rd_pkg::slv_ar_t s1_ar_o,
	output logic s1_arvalid_o,
	input  logic s1_arready_i,
	input  axi_rd_pkg::slv_r_t s1_r_i,
	input  logic s1_rvalid_i,
	output logic s1_rready_o
);
	import axi_rd_pkg::*;
	import xbar_map_pkg::*;

	mst_ar_t [N_MST-1:0] m_ar;
	mst_r_t [N_MST-1:0] m_r;
	logic [N_MST-1:0] m_arvalid;
	logic [N_MST-1:0] m_arready;
	logic [N_MST-1:0] m_rvalid;
	logic [N_MST-1:0] m_rready;

	slv_ar_t [N_MST-1:0] fsm_req;
	tgt_idx_t [N_MST-1:0] fsm_tgt;
	logic [N_MST-1:0] fsm_valid;
	logic [N_MST-1:0][N_TGT-1:0] fsm_gnt;
	logic [N_MST-1:0][N_TGT-1:0] mp_gnt;
	logic [N_MST-1:0][N_TGT-1:0] mp_claim;

	slv_ar_t [N_TGT-1:0] tp_ar;
	logic [N_TGT-1:0] tp_arvalid;
	logic [N_TGT-1:0][N_MST-1:0] tp_gnt;
	logic [N_TGT-1:0][N_MST-1:0] rt_gnt;
	logic [N_TGT-1:0][N_MST-1:0] rt_claim;
	logic [N_TGT-1:0] tgt_arready;
	slv_r_t [N_TGT-1:0] tgt_r;
	logic [N_TGT-1:0] tgt_rvalid;
	logic [N_TGT-1:0] rt_rready;
	logic [N_TGT-1:0] rt_stream;

	slv_r_t err_r;
	logic err_arready;
	logic err_rvalid;

	assign m_ar = {m1_ar_i, m0_ar_i};
	assign m_arvalid = {m1_arvalid_i, m0_arvalid_i};
	assign m_rready = {m1_rready_i, m0_rready_i};
	assign {m1_arready_o, m0_arready_o} = m_arready;
	assign {m1_rvalid_o, m0_rvalid_o} = m_rvalid;
	assign m0_r_o = m_r[0];
	assign m1_r_o = m_r[1];

	assign s0_ar_o = tp_ar[0];
	assign s1_ar_o = tp_ar[1];
	assign s0_arvalid_o = tp_arvalid[0];
	assign s1_arvalid_o = tp_arvalid[1];
	assign s0_rready_o = rt_rready[0];
	assign s1_rready_o = rt_rready[1];

	// Error target sits at the top index
	assign tgt_arready = {err_arready, s1_arready_i, s0_arready_i};
	assign tgt_r = {err_r, s1_r_i, s0_r_i};
	assign tgt_rvalid = {err_rvalid, s1_rvalid_i, s0_rvalid_i};

	for (genvar m = 0; m < N_MST; m++) begin : g_mst
		ar_req_fsm u_ar_fsm (
			.clk(clk),
			.rstn(rstn),
			.mst_idx_i(mst_idx_t'(m)),
			.ar_i(m_ar[m]),
			.arvalid_i(m_arvalid[m]),
			.gnt_i(fsm_gnt[m]),
			.tgt_arready_i(tgt_arready),
			.arready_o(m_arready[m]),
			.req_o(fsm_req[m]),
			.tgt_o(fsm_tgt[m]),
			.req_valid_o(fsm_valid[m])
		);

		r_master_port u_r_port (
			.clk(clk),
			.rstn(rstn),
			.claim_i(mp_claim[m]),
			.stream_i(rt_stream),
			.tgt_r_i(tgt_r),
			.tgt_rvalid_i(tgt_rvalid),
			.gnt_o(mp_gnt[m]),
			.r_o(m_r[m]),
			.rvalid_o(m_rvalid[m])
		);
	end

	for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
		ar_target_port u_ar_port (
			.clk(clk),
			.rstn(rstn),
			.tgt_idx_i(tgt_idx_t'(t)),
			.mst_req_i(fsm_req),
			.mst_tgt_i(fsm_tgt),
			.mst_valid_i(fsm_valid),
			.arready_i(tgt_arready[t]),
			.gnt_o(tp_gnt[t]),
			.ar_o(tp_ar[t]),
			.arvalid_o(tp_arvalid[t])
		);

		r_resp_router u_r_router (
			.clk(clk),
			.rstn(rstn),
			.r_i(tgt_r[t]),
			.rvalid_i(tgt_rvalid[t]),
			.gnt_i(rt_gnt[t]),
			.mst_rready_i(m_rready),
			.rready_o(rt_rready[t]),
			.claim_o(rt_claim[t]),
			.stream_o(rt_stream[t])
		);

		// Grants and claims are indexed the other way round on each side
		for (genvar m = 0; m < N_MST; m++) begin : g_xpose
			assign fsm_gnt[m][t] = tp_gnt[t][m];
			assign rt_gnt[t][m] = mp_gnt[m][t];
			assign mp_claim[m][t] = rt_claim[t][m];
		end
	end

	decerr_read_target u_decerr (
		.clk(clk),
		.rstn(rstn),
		.ar_i(tp_ar[TGT_DECERR]),
		.arvalid_i(tp_arvalid[TGT_DECERR]),
		.rready_i(rt_rready[TGT_DECERR]),
		.arready_o(err_arready),
		.r_o(err_r),
		.rvalid_o(err_rvalid)
	);

endmodule

// File: rtl/axi_rd_xbar_settings.svh
/*
 * Widths, port counts and the address map of the read crossbar.
 * Included by the packages, the address decoder and the testbench.
 */
`ifndef AXI_RD_XBAR_SETTINGS_SVH
`define AXI_RD_XBAR_SETTINGS_SVH

`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_ID_W 4

`define XBAR_N_MST 2
`define XBAR_N_SLV 2

// Inclusive windows checked in this order
`define XBAR_SLV0_BASE 32'h0000_0000
`define XBAR_SLV0_LIMIT 32'h0000_FFFF
`define XBAR_SLV1_BASE 32'h0001_0000
`define XBAR_SLV1_LIMIT 32'h0001_FFFF

`endif

// File: rtl/decerr_read_target.sv
/*
 * Internal target for addresses outside every window. Accepts one read at a
 * time and returns len+1 beats of zero data with DECERR.
 */
module decerr_read_target (
	input  logic clk,
	input  logic rstn,
	input  axi_rd_pkg::slv_ar_t ar_i,
	input  logic arvalid_i,
	input  logic rready_i,
	output logic arready_o,
	output axi_rd_pkg::slv_r_t r_o,
	output logic rvalid_o
);
	import axi_rd_pkg::*;

	typedef enum logic {
		ERR_ACCEPT,
		ERR_RESPOND
	} err_state_e;

	err_state_e state;
	sid_t id_q;
	len_t len_q;
	len_t cnt;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ERR_ACCEPT;
			cnt <= '0;
		end else if (state == ERR_ACCEPT) begin
			if (arvalid_i) begin
				cnt <= '0;
				state <= ERR_RESPOND;
			end
		end else if (rready_i) begin
			if (cnt == len_q) begin
				state <= ERR_ACCEPT;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ERR_ACCEPT && arvalid_i) begin
			id_q <= ar_i.id;
			len_q <= ar_i.len;
		end
	end

	assign arready_o = (state == ERR_ACCEPT);
	assign rvalid_o = (state == ERR_RESPOND);
	assign r_o.id = id_q;
	assign r_o.data = '0;
	assign r_o.resp = RESP_DECERR;
	assign r_o.last = rvalid_o && (cnt == len_q);

endmodule

// File: rtl/r_master_port.sv
/*
 * R side of one master. Arbitrates among targets claiming this master and
 * forwards the streaming winner's beats with the master index stripped.
 */
module r_master_port (
	input  logic clk,
	input  logic rstn,
	input  logic [xbar_map_pkg::N_TGT-1:0] claim_i,
	input  logic [xbar_map_pkg::N_TGT-1:0] stream_i,
	input  axi_rd_pkg::slv_r_t [xbar_map_pkg::N_TGT-1:0] tgt_r_i,
	input  logic [xbar_map_pkg::N_TGT-1:0] tgt_rvalid_i,
	output logic [xbar_map_pkg::N_TGT-1:0] gnt_o,
	output axi_rd_pkg::mst_r_t r_o,
	output logic rvalid_o
);
	import axi_rd_pkg::*;
	import xbar_map_pkg::*;

	tgt_idx_t gnt_id;
	slv_r_t beat;
	logic active;

	rr_arbiter #(
		.N_REQ(N_TGT)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(claim_i),
		.gnt_o(gnt_o),
		.gnt_id_o(gnt_id)
	);

	assign beat = tgt_r_i[gnt_id];
	assign active = (gnt_o != '0) && stream_i[gnt_id];

	always_comb begin
		r_o = '0;
		if (active) begin
			r_o.id = mid_t'(beat.id);
			r_o.data = beat.data;
			r_o.resp = beat.resp;
			r_o.last = beat.last;
		end
	end

	assign rvalid_o = active && tgt_rvalid_i[gnt_id];

endmodule

// File: rtl/r_resp_router.sv
/*
 * R side of one target. On the first beat of a burst it claims the master named
 * in the top ID bits, then streams the burst once that master grants it.
 */
module r_resp_router (
	input  logic clk,
	input  logic rstn,
	input  axi_rd_pkg::slv_r_t r_i,
	input  logic rvalid_i,
	input  logic [xbar_map_pkg::N_MST-1:0] gnt_i,
	input  logic [xbar_map_pkg::N_MST-1:0] mst_rready_i,
	output logic rready_o,
	output logic [xbar_map_pkg::N_MST-1:0] claim_o,
	output logic stream_o
);
	import axi_rd_pkg::*;
	import xbar_map_pkg::*;

	rr_state_e state;
	mst_idx_t sel;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= RR_IDLE;
			sel <= '0;
		end else begin
			case (state)
				RR_IDLE: begin
					if (rvalid_i) begin
						sel <= mst_idx_t'(r_i.id >> $bits(mid_t));
						state <= RR_CLAIM;
					end
				end
				RR_CLAIM: begin
					if (gnt_i[sel]) begin
						state <= RR_STREAM;
					end
				end
				RR_STREAM: begin
					if (rvalid_i && rready_o && r_i.last) begin
						state <= RR_IDLE;
					end
				end
				default: state <= RR_IDLE;
			endcase
		end
	end

	// Claim is kept through STREAM so the master port holds its grant
	always_comb begin
		claim_o = '0;
		if (state != RR_IDLE) begin
			claim_o[sel] = 1'b1;
		end
	end

	assign stream_o = (state == RR_STREAM);
	assign rready_o = stream_o ? mst_rready_i[sel] : 1'b0;

	// Beats only move while the master port still grants this target
	assert property (@(posedge clk) disable iff (!rstn)
		rready_o |-> (state == RR_STREAM) && gnt_i[sel]);

endmodule

// File: rtl/rr_arbiter.sv
/*
 * Round-robin arbiter with a registered one-hot grant that is held for as long
 * as the granted request stays high.
 */
module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic clk,
	input  logic rstn,
	input  logic [N_REQ-1:0] req_i,
	output logic [N_REQ-1:0] gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);
	localparam int IDW = $clog2(N_REQ);

	logic [N_REQ-1:0] last_gnt;
	logic [N_REQ-1:0] above;
	logic [N_REQ-1:0] masked;
	logic [N_REQ-1:0] pick;

	function automatic logic [IDW-1:0] onehot_to_idx(logic [N_REQ-1:0] oh);
		logic [IDW-1:0] idx;
		idx = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (oh[i]) begin
				idx = IDW'(i);
			end
		end
		return idx;
	endfunction

	// Requests strictly above the last winner get first pick
	assign above = ~((last_gnt << 1) - 1'b1);
	assign masked = req_i & above;
	assign pick = (masked != '0) ? (masked & (~masked + 1'b1)) : (req_i & (~req_i + 1'b1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= '0;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else if (gnt_o == '0) begin
			if (req_i != '0) begin
				gnt_o <= pick;
				last_gnt <= pick;
				gnt_id_o <= onehot_to_idx(pick);
			end
		end else if ((gnt_o & req_i) == '0) begin
			gnt_o <= '0;
		end
	end

	// A fresh grant always goes to a requester of the previous cycle
	assert property (@(posedge clk) disable iff (!rstn)
		(gnt_o != '0) && ($past(gnt_o) == '0) |-> ($past(req_i) & gnt_o) != '0);

endmodule

// File: rtl/xbar_map_pkg.sv
/*
 * Port and target indices of the crossbar and the encodings of its control FSMs.
 * Target indices above the real slaves name the internal error target.
 */
`include "axi_rd_xbar_settings.svh"

package xbar_map_pkg;

	localparam int N_MST = `XBAR_N_MST;
	localparam int N_SLV = `XBAR_N_SLV;
	// Real slaves plus the error target
	localparam int N_TGT = `XBAR_N_SLV + 1;

	typedef logic [$clog2(N_MST)-1:0] mst_idx_t;
	typedef logic [$clog2(N_TGT)-1:0] tgt_idx_t;

	localparam tgt_idx_t TGT_DECERR = tgt_idx_t'(N_SLV);

	typedef enum logic [1:0] {
		AR_IDLE,
		AR_DECODE,
		AR_REQUEST
	} ar_state_e;

	typedef enum logic [1:0] {
		RR_IDLE,
		RR_CLAIM,
		RR_STREAM
	} rr_state_e;

endpackage
